// ==== Makefile ====
# Verilator build and run for the shift unit testbench

SRCS := $(wildcard rtl/*.sv test/*.sv)
BIN  := obj_dir/Vtb_shift_unit

.PHONY: all run clean

all: run

$(BIN): list.f $(SRCS)
	verilator --binary --timing -f list.f --top-module tb_shift_unit -Mdir obj_dir

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== list.f ====
rtl/shift_pkg.sv
rtl/shift_control.sv
rtl/left_shifter.sv
rtl/right_shifter.sv
rtl/shift_combine.sv
rtl/shift_unit_top.sv
test/tb_shift_unit.sv

// ==== rtl/left_shifter.sv ====
// One-hot left shifter
`default_nettype none

module left_shifter (
    input  shift_pkg::data_t data_q,
    input  shift_pkg::sel_t  left_sel,
    output shift_pkg::data_t left_out
);

    // part[s][d] is what source lane s puts into output lane d.
    logic [shift_pkg::LANE_W-1:0] part
        [shift_pkg::DATA_W/shift_pkg::LANE_W][shift_pkg::DATA_W/shift_pkg::LANE_W];

    always_comb begin
        for (int s = 0; s < shift_pkg::DATA_W / shift_pkg::LANE_W; s++) begin
            for (int d = 0; d < shift_pkg::DATA_W / shift_pkg::LANE_W; d++) begin
                part[s][d] = '0;
                // a left shift only moves bits up, so lower lanes stay empty.
                if (d >= s) begin
                    for (int b = 0; b < shift_pkg::LANE_W; b++) begin
                        for (int j = 0; j < shift_pkg::LANE_W; j++) begin
                            if (d * shift_pkg::LANE_W + b >= s * shift_pkg::LANE_W + j) begin
                                part[s][d][b] = part[s][d][b]
                                    | (data_q[s * shift_pkg::LANE_W + j]
                                    & left_sel[(d - s) * shift_pkg::LANE_W + b - j]);
                            end
                        end
                    end
                end
            end
        end
    end

    // or the lane contributions together.
    always_comb begin
        left_out = '0;
        for (int d = 0; d < shift_pkg::DATA_W / shift_pkg::LANE_W; d++) begin
            for (int s = 0; s < shift_pkg::DATA_W / shift_pkg::LANE_W; s++) begin
                left_out[d * shift_pkg::LANE_W +: shift_pkg::LANE_W] =
                    left_out[d * shift_pkg::LANE_W +: shift_pkg::LANE_W] | part[s][d];
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/right_shifter.sv ====
// One-hot right shifter with fill
`default_nettype none

module right_shifter (
    input  shift_pkg::data_t data_q,
    input  shift_pkg::sel_t  right_sel,
    input  logic             fill,
    output shift_pkg::data_t right_out
);

    // part[s][d] is what source lane s puts into output lane d.
    logic [shift_pkg::LANE_W-1:0] part
        [shift_pkg::DATA_W/shift_pkg::LANE_W][shift_pkg::DATA_W/shift_pkg::LANE_W];
    shift_pkg::data_t lane_or;
    shift_pkg::data_t vacated;

    always_comb begin
        for (int s = 0; s < shift_pkg::DATA_W / shift_pkg::LANE_W; s++) begin
            for (int d = 0; d < shift_pkg::DATA_W / shift_pkg::LANE_W; d++) begin
                part[s][d] = '0;
                // bits only move down, so higher lanes stay empty.
                if (s >= d) begin
                    for (int b = 0; b < shift_pkg::LANE_W; b++) begin
                        for (int j = 0; j < shift_pkg::LANE_W; j++) begin
                            if (s * shift_pkg::LANE_W + j >= d * shift_pkg::LANE_W + b) begin
                                part[s][d][b] = part[s][d][b]
                                    | (data_q[s * shift_pkg::LANE_W + j]
                                    & right_sel[(s - d) * shift_pkg::LANE_W + j - b]);
                            end
                        end
                    end
                end
            end
        end
    end

    always_comb begin
        lane_or = '0;
        for (int d = 0; d < shift_pkg::DATA_W / shift_pkg::LANE_W; d++) begin
            for (int s = 0; s < shift_pkg::DATA_W / shift_pkg::LANE_W; s++) begin
                lane_or[d * shift_pkg::LANE_W +: shift_pkg::LANE_W] =
                    lane_or[d * shift_pkg::LANE_W +: shift_pkg::LANE_W] | part[s][d];
            end
        end
    end

    // bit i is vacated by any shift above 31 - i.
    always_comb begin
        vacated = '0;
        for (int i = 1; i < shift_pkg::DATA_W; i++) begin
            for (int k = shift_pkg::DATA_W - i; k < shift_pkg::DATA_W; k++) begin
                vacated[i] = vacated[i] | right_sel[k];
            end
        end
    end

    assign right_out = lane_or | ({shift_pkg::DATA_W{fill}} & vacated);

endmodule

`default_nettype wire

// ==== rtl/shift_combine.sv ====
// Shift result combine stage
`default_nettype none

module shift_combine (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             valid_q,
    input  shift_pkg::data_t left_out,
    input  shift_pkg::data_t right_out,
    output logic             out_valid,
    output shift_pkg::data_t dout,
    output logic             zero
);

    shift_pkg::data_t result;

    // joins rotate halves.
    // single-direction shifts see zeros from the idle side.
    assign result = left_out | right_out;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            dout      <= '0;
            zero      <= 1'b0;
        end else begin
            out_valid <= valid_q;
            if (valid_q) begin
                dout <= result;
                zero <= (result == '0);
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/shift_control.sv ====
// Shift control stage
`default_nettype none

module shift_control (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  shift_pkg::data_t   din,
    input  shift_pkg::amt_t    amt,
    input  shift_pkg::op_t     op,
    output logic               valid_q,
    output shift_pkg::data_t   data_q,
    output shift_pkg::sel_t    left_sel,
    output shift_pkg::sel_t    right_sel,
    output logic               fill
);

    shift_pkg::amt_t ror_amt;
    shift_pkg::sel_t left_d;
    shift_pkg::sel_t right_d;
    logic            fill_d;

    // 32 minus amt, wraps to 0 for amt 0.
    assign ror_amt = ~amt + shift_pkg::amt_t'(1);

    always_comb begin
        left_d  = '0;
        right_d = '0;
        fill_d  = 1'b0;
        case (op)
            shift_pkg::OP_SLL: begin
                left_d = shift_pkg::sel_t'(1) << amt;
            end
            shift_pkg::OP_SRL: begin
                right_d = shift_pkg::sel_t'(1) << amt;
            end
            shift_pkg::OP_SRA: begin
                right_d = shift_pkg::sel_t'(1) << amt;
                fill_d  = din[shift_pkg::DATA_W-1];
            end
            shift_pkg::OP_ROR: begin
                right_d = shift_pkg::sel_t'(1) << amt;
                // no left half for a zero rotate.
                if (amt != '0) begin
                    left_d = shift_pkg::sel_t'(1) << ror_amt;
                end
            end
            default: begin
                left_d = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q   <= 1'b0;
            data_q    <= '0;
            left_sel  <= '0;
            right_sel <= '0;
            fill      <= 1'b0;
        end else begin
            valid_q <= in_valid;
            if (in_valid) begin
                data_q    <= din;
                left_sel  <= left_d;
                right_sel <= right_d;
                fill      <= fill_d;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/shift_pkg.sv ====
// Shift unit shared definitions
`default_nettype none

package shift_pkg;

    // datapath geometry.
    localparam int DATA_W = 32;
    localparam int AMT_W  = 5;
    localparam int LANE_W = 8;

    // operand and result word.
    typedef logic [DATA_W-1:0] data_t;

    // shift amount.
    typedef logic [AMT_W-1:0] amt_t;

    // one-hot select, bit k means shift by k.
    // all zeros means the shifter contributes nothing.
    typedef logic [DATA_W-1:0] sel_t;

    // operation code.
    typedef logic [1:0] op_t;

    // logical left.
    localparam op_t OP_SLL = 2'd0;
    // logical right.
    localparam op_t OP_SRL = 2'd1;
    // arithmetic right.
    localparam op_t OP_SRA = 2'd2;
    // rotate right.
    localparam op_t OP_ROR = 2'd3;

endpackage

`default_nettype wire

// ==== rtl/shift_unit_top.sv ====
// Two-stage shift unit
`default_nettype none

module shift_unit_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  shift_pkg::data_t din,
    input  shift_pkg::amt_t  amt,
    input  shift_pkg::op_t   op,
    output logic             out_valid,
    output shift_pkg::data_t dout,
    output logic             zero
);

    logic             valid_q;
    logic             fill;
    shift_pkg::data_t data_q;
    shift_pkg::sel_t  left_sel;
    shift_pkg::sel_t  right_sel;
    shift_pkg::data_t left_out;
    shift_pkg::data_t right_out;

    shift_control shift_control_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .din       (din),
        .amt       (amt),
        .op        (op),
        .valid_q   (valid_q),
        .data_q    (data_q),
        .left_sel  (left_sel),
        .right_sel (right_sel),
        .fill      (fill)
    );

    left_shifter left_shifter_i (
        .data_q   (data_q),
        .left_sel (left_sel),
        .left_out (left_out)
    );

    right_shifter right_shifter_i (
        .data_q    (data_q),
        .right_sel (right_sel),
        .fill      (fill),
        .right_out (right_out)
    );

    shift_combine shift_combine_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_q   (valid_q),
        .left_out  (left_out),
        .right_out (right_out),
        .out_valid (out_valid),
        .dout      (dout),
        .zero      (zero)
    );

endmodule

`default_nettype wire

// ==== test/tb_shift_unit.sv ====
// Shift unit testbench
`default_nettype none

module tb_shift_unit;

    localparam int TOTAL_OPS = 400 + 16 + 16 + 16 + 100;
    // four cycles per operation covers the widest sparse gap.
    localparam int TIMEOUT   = TOTAL_OPS * 8 * 4 + 2000;

    logic             clk;
    logic             rst_n;
    logic             in_valid;
    shift_pkg::data_t din;
    shift_pkg::amt_t  amt;
    shift_pkg::op_t   op;
    logic             out_valid;
    shift_pkg::data_t dout;
    logic             zero;

    logic [31:0]      lfsr_state = 32'd68617;
    int               cyc = 0;
    int               err_count = 0;
    int               check_count = 0;
    int               test_count = 0;
    shift_pkg::data_t exp_data[$];
    int               exp_cycle[$];
    shift_pkg::data_t mon_data;
    int               mon_cycle;

    shift_unit_top shift_unit_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .din       (din),
        .amt       (amt),
        .op        (op),
        .out_valid (out_valid),
        .dout      (dout),
        .zero      (zero)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // expected result straight from the operation definitions.
    function automatic shift_pkg::data_t shift_model(input shift_pkg::data_t d,
                                                     input shift_pkg::amt_t a,
                                                     input shift_pkg::op_t o);
        shift_pkg::data_t r;
        case (o)
            shift_pkg::OP_SLL: r = d << a;
            shift_pkg::OP_SRL: r = d >> a;
            shift_pkg::OP_SRA: r = $signed(d) >>> a;
            default:           r = (d >> a) | (d << (shift_pkg::DATA_W - int'(a)));
        endcase
        return r;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        check_count++;
        if (actual !== expected) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, msg, actual, expected);
            err_count++;
        end
    endtask

    // called at a falling edge, returns at the next one.
    task automatic send_op(input shift_pkg::data_t d, input shift_pkg::amt_t a,
                           input shift_pkg::op_t o);
        in_valid = 1'b1;
        din      = d;
        amt      = a;
        op       = o;
        exp_data.push_back(shift_model(d, a, o));
        // two register stages between the input edge and the output.
        exp_cycle.push_back(cyc + 2);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic drain_outputs();
        int waited;
        waited = 0;
        while (exp_data.size() != 0 && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (exp_data.size() != 0) begin
            $display("error at %0t: %0d results never appeared", $time, exp_data.size());
            err_count += exp_data.size();
            exp_data.delete();
            exp_cycle.delete();
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic end_test(input string name, input int errs_before);
        drain_outputs();
        test_count++;
        $display("test %s: %0d errors", name, err_count - errs_before);
    endtask

    // every out_valid must match one queued input.
    always @(negedge clk) begin
        if (out_valid) begin
            if (exp_data.size() == 0) begin
                $display("error at %0t: out_valid rose without a matching input", $time);
                err_count++;
            end else begin
                mon_data  = exp_data.pop_front();
                mon_cycle = exp_cycle.pop_front();
                check_value(dout, mon_data, "dout");
                check_value({31'b0, zero}, {31'b0, (mon_data == '0)}, "zero");
                check_value(cyc, mon_cycle, "latency");
            end
        end
    end

    initial begin
        #(TIMEOUT);
        $display("timeout: the run did not finish in time");
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        int          errs;
        logic [31:0] r;
        logic [31:0] d;
        in_valid = 1'b0;
        din      = '0;
        amt      = '0;
        op       = '0;
        rst_n    = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        errs = err_count;
        repeat (10) begin
            @(negedge clk);
            check_value({31'b0, out_valid}, 32'd0, "out_valid after reset");
        end
        end_test("reset_idle", errs);

        errs = err_count;
        repeat (400) begin
            d = rand_bits(32);
            r = rand_bits(7);
            send_op(d, r[4:0], r[6:5]);
        end
        end_test("random_ops", errs);

        errs = err_count;
        for (int i = 0; i < 16; i++) begin
            d = rand_bits(32);
            send_op(d, 5'd0, shift_pkg::op_t'(i % 4));
        end
        end_test("zero_amount", errs);

        errs = err_count;
        repeat (8) begin
            d = rand_bits(32) | 32'h8000_0000;
            send_op(d, 5'd31, shift_pkg::OP_SRA);
            send_op(d, 5'd31, shift_pkg::OP_SRL);
        end
        end_test("sra_negative", errs);

        errs = err_count;
        repeat (8) begin
            r = rand_bits(7);
            send_op('0, r[4:0], r[6:5]);
        end
        // large left shifts push every set bit out.
        repeat (8) begin
            r = rand_bits(3);
            d = rand_bits(32) & 32'hffff_ff00;
            send_op(d, {2'b11, r[2:0]}, shift_pkg::OP_SLL);
        end
        end_test("zero_flag", errs);

        errs = err_count;
        repeat (100) begin
            d = rand_bits(32);
            r = rand_bits(9);
            send_op(d, r[4:0], r[6:5]);
            repeat (r[8:7]) @(negedge clk);
        end
        end_test("sparse_input", errs);

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
